// File: afe_ctl_settings.svh
////////////////////
// afe control settings
// widths, spi register map and the short phase lengths used for simulation
////////////////////

`ifndef AFE_CTL_SETTINGS_SVH
`define AFE_CTL_SETTINGS_SVH

// conditioning word and register widths
`define AFE_NUM_BITS   29
`define AFE_REG_W      32

// spi frame layout, 8 bit command then 32 data bits
`define AFE_ADDR_W     7
`define AFE_CMD_BITS   8
`define AFE_FRAME_BITS 40

// register map, other addresses read zero
`define AFE_ADDR_LED     7'd1
`define AFE_ADDR_MODE    7'd2
`define AFE_ADDR_DIRECT  7'd3
`define AFE_ADDR_DIRECT2 7'd4

// phase lengths in clk cycles
`define AFE_ALT_PERIOD 16    // direct / direct2 swap
`define AFE_AZ_PERIOD  8     // one auto-zero phase
`define AFE_AZ_LO_CODE 3     // azmux select of the zero reference

`endif

// File: afe_ctl_pkg.sv
////////////////////
// afe control types
// conditioning word layout, mux control, mode codes and the register file
////////////////////

`default_nettype none

`include "afe_ctl_settings.svh"

package afe_ctl_pkg;

  // one 4:1 analog mux, enable on top
  typedef struct packed {
    logic       en;
    logic [2:0] addr;
  } mux_ctl_t;

  // the 29 bit conditioning word, msb first
  typedef struct packed {
    logic       spi_interrupt;
    logic       meas_complete;
    logic       cmpr_latch;
    logic [3:0] adcmux;         // adc current switches
    logic [7:0] monitor;
    logic       led0;
    logic       sig_pc_sw;      // pre-charge switch
    mux_ctl_t   himux2;
    mux_ctl_t   himux;
    mux_ctl_t   azmux;          // bits 3:0
  } cond_word_t;

  typedef enum logic [2:0] {
    MODE_ZERO   = 3'd0,
    MODE_ONES   = 3'd1,
    MODE_COUNT  = 3'd2,
    MODE_DIRECT = 3'd3,
    MODE_ALT    = 3'd4,
    MODE_AZ     = 3'd5          // 6 and 7 fall back to zero
  } afe_mode_e;

  typedef struct packed {
    logic [`AFE_REG_W-1:0] led;
    logic [`AFE_REG_W-1:0] mode;
    logic [`AFE_REG_W-1:0] direct;
    logic [`AFE_REG_W-1:0] direct2;
  } reg_file_t;

endpackage

`default_nettype wire

// File: spi_reg_bank.sv
////////////////////
// spi register bank
// mode 0 slave sampled in clk, 40 bit frames, four 32 bit registers
// every frame reads back the addressed register on miso
////////////////////

`default_nettype none

`include "afe_ctl_settings.svh"

module spi_reg_bank
  import afe_ctl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      spi_clk,
  input  logic      spi_cs,     // active low
  input  logic      spi_mosi,
  output logic      spi_miso,
  output reg_file_t regs
);

  localparam logic [5:0] CMD_CNT   = 6'(`AFE_CMD_BITS);
  localparam logic [5:0] FRAME_CNT = 6'(`AFE_FRAME_BITS);

  ////////////////////
  // pin synchronisers

  logic [1:0] sclk_sync, cs_sync, mosi_sync;
  logic       sclk_q, cs_q;     // previous synced values for edge detect
  logic       sclk_rise, sclk_fall, cs_rise, cs_act, mosi_s;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_sync <= 2'b00;
      cs_sync   <= 2'b11;      // idle high
      mosi_sync <= 2'b00;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], spi_clk};
      cs_sync   <= {cs_sync[0], spi_cs};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sclk_q    <= sclk_sync[1];
      cs_q      <= cs_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] & ~sclk_q;
  assign sclk_fall = ~sclk_sync[1] & sclk_q;
  assign cs_rise   = cs_sync[1] & ~cs_q;   // end of frame
  assign cs_act    = ~cs_sync[1];
  assign mosi_s    = mosi_sync[1];

  ////////////////////
  // frame assembly

  logic [5:0]               bit_cnt;     // saturates, long frames never match
  logic [`AFE_CMD_BITS-1:0] cmd_sr;      // {wr, addr}
  logic [`AFE_REG_W-1:0]    data_sr;
  logic [`AFE_REG_W-1:0]    load_sr;     // readback shifter
  logic [`AFE_REG_W-1:0]    rd_val;
  logic [`AFE_ADDR_W-1:0]   addr;
  reg_file_t                regs_q;

  assign addr = cmd_sr[`AFE_ADDR_W-1:0];

  // command bits first, then data, msb first
  always_ff @(posedge clk)
  begin
    if (cs_act && sclk_rise)
    begin
      if (bit_cnt < CMD_CNT)
        cmd_sr <= {cmd_sr[`AFE_CMD_BITS-2:0], mosi_s};
      else
        data_sr <= {data_sr[`AFE_REG_W-2:0], mosi_s};
    end
  end

  always_comb
  begin
    case (addr)
      `AFE_ADDR_LED:     rd_val = regs_q.led;
      `AFE_ADDR_MODE:    rd_val = regs_q.mode;
      `AFE_ADDR_DIRECT:  rd_val = regs_q.direct;
      `AFE_ADDR_DIRECT2: rd_val = regs_q.direct2;
      default:           rd_val = '0;          // unmapped
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      load_sr <= '0;
      regs_q  <= '0;
    end
    else if (cs_rise)
    begin
      bit_cnt <= '0;
      load_sr <= '0;
      // write only on an exact 40 bit frame with the write bit set
      if (bit_cnt == FRAME_CNT && cmd_sr[`AFE_CMD_BITS-1])
      begin
        case (addr)
          `AFE_ADDR_LED:     regs_q.led     <= data_sr;
          `AFE_ADDR_MODE:    regs_q.mode    <= data_sr;
          `AFE_ADDR_DIRECT:  regs_q.direct  <= data_sr;
          `AFE_ADDR_DIRECT2: regs_q.direct2 <= data_sr;
          default:           regs_q         <= regs_q;
        endcase
      end
    end
    else if (cs_act)
    begin
      if (sclk_rise && bit_cnt != '1)
        bit_cnt <= bit_cnt + 6'd1;
      if (sclk_fall)
      begin
        if (bit_cnt == CMD_CNT)
          load_sr <= rd_val;                          // command complete, present value
        else
          load_sr <= {load_sr[`AFE_REG_W-2:0], 1'b0}; // next bit
      end
    end
  end

  assign spi_miso = load_sr[`AFE_REG_W-1];
  assign regs     = regs_q;

endmodule

`default_nettype wire

// File: az_modulator.sv
////////////////////
// auto-zero modulator
// alternates azmux between signal and zero reference, with pre-charge, led and monitor
////////////////////

`default_nettype none

`include "afe_ctl_settings.svh"

module az_modulator
  import afe_ctl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,          // mode is auto-zero
  input  mux_ctl_t   az_mux_val,   // signal select from direct
  output mux_ctl_t   az_azmux,
  output logic       az_pc_sw,
  output logic       az_led,
  output logic [7:0] az_monitor
);

  localparam int CNT_W = $clog2(`AFE_AZ_PERIOD);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`AFE_AZ_PERIOD - 1);
  localparam mux_ctl_t AZ_LO = '{en: 1'b1, addr: 3'(`AFE_AZ_LO_CODE)};

  logic [CNT_W-1:0] cnt_q;
  logic             phase_q;   // 0 signal, 1 zero
  logic             led_q;

  ////////////////////
  // phase sequencer
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cnt_q   <= '0;
      phase_q <= 1'b0;
      led_q   <= 1'b0;
    end
    else if (!run)
    begin
      cnt_q   <= '0;          // park in signal phase
      phase_q <= 1'b0;
    end
    else if (cnt_q == CNT_LAST)
    begin
      cnt_q   <= '0;
      phase_q <= ~phase_q;
      if (phase_q)
        led_q <= ~led_q;      // once per signal + zero pair
    end
    else
      cnt_q <= cnt_q + 1'b1;
  end

  ////////////////////
  // registered outputs, all fields from the same state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      az_azmux   <= '0;
      az_pc_sw   <= 1'b0;
      az_led     <= 1'b0;
      az_monitor <= '0;
    end
    else
    begin
      az_azmux   <= phase_q ? AZ_LO : az_mux_val;
      az_pc_sw   <= ~phase_q;                    // closed while on signal
      az_led     <= led_q;
      az_monitor <= {6'b0, led_q, phase_q};
    end
  end

endmodule

`default_nettype wire

// File: cond_mode_mux.sv
////////////////////
// conditioning mode mux
// count and alternation generators, registered 8 way source select
////////////////////

`default_nettype none

`include "afe_ctl_settings.svh"

module cond_mode_mux
  import afe_ctl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  reg_file_t  regs,
  input  mux_ctl_t   az_azmux,
  input  logic       az_pc_sw,
  input  logic       az_led,
  input  logic [7:0] az_monitor,
  output cond_word_t cond_out
);

  localparam int ALT_W = $clog2(`AFE_ALT_PERIOD);
  localparam logic [ALT_W-1:0] ALT_LAST = ALT_W'(`AFE_ALT_PERIOD - 1);

  logic [`AFE_NUM_BITS-1:0] count_q;   // free running pattern
  logic [ALT_W-1:0]         alt_cnt;
  logic                     alt_sel;   // 0 direct, 1 direct2
  afe_mode_e                mode;
  cond_word_t               direct_w, direct2_w, alt_w, az_w, next_w;

  ////////////////////
  // pattern generators
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count_q <= '0;
      alt_cnt <= '0;
      alt_sel <= 1'b0;
    end
    else
    begin
      count_q <= count_q + 1'b1;    // wraps mod 2^29
      if (alt_cnt == ALT_LAST)
      begin
        alt_cnt <= '0;
        alt_sel <= ~alt_sel;
      end
      else
        alt_cnt <= alt_cnt + 1'b1;
    end
  end

  // only the low 29 bits of the direct registers map to pins
  assign direct_w  = cond_word_t'(regs.direct[`AFE_NUM_BITS-1:0]);
  assign direct2_w = cond_word_t'(regs.direct2[`AFE_NUM_BITS-1:0]);
  assign alt_w     = alt_sel ? direct2_w : direct_w;
  assign mode      = afe_mode_e'(regs.mode[2:0]);

  // auto-zero word, modulator owns azmux, pre-charge, led and monitor
  always_comb
  begin
    az_w           = direct_w;
    az_w.azmux     = az_azmux;
    az_w.sig_pc_sw = az_pc_sw;
    az_w.led0      = az_led;
    az_w.monitor   = az_monitor;
  end

  ////////////////////
  // source select
  always_comb
  begin
    case (mode)
      MODE_ZERO:   next_w = '0;
      MODE_ONES:   next_w = '1;
      MODE_COUNT:  next_w = cond_word_t'(count_q);
      MODE_DIRECT: next_w = direct_w;
      MODE_ALT:    next_w = alt_w;
      MODE_AZ:     next_w = az_w;
      default:     next_w = '0;     // codes 6, 7
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cond_out <= '0;
    else
      cond_out <= next_w;
  end

endmodule

`default_nettype wire

// File: afe_ctl_top.sv
////////////////////
// afe control top
// spi register bank, auto-zero modulator and mode mux to the pins
////////////////////

`default_nettype none

module afe_ctl_top
  import afe_ctl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spi_clk,
  input  logic       spi_cs,      // active low
  input  logic       spi_mosi,
  output logic       spi_miso,
  output cond_word_t cond_out     // analog muxes, pre-charge, led, monitor, adc
);

  reg_file_t  regs;
  logic       run;
  mux_ctl_t   az_azmux;
  logic       az_pc_sw;
  logic       az_led;
  logic [7:0] az_monitor;

  spi_reg_bank i_spi_reg_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .regs     (regs)
  );

  // modulator only steps while auto-zero is selected
  assign run = (afe_mode_e'(regs.mode[2:0]) == MODE_AZ);

  az_modulator i_az_modulator (
    .clk        (clk),
    .rst_n      (rst_n),
    .run        (run),
    .az_mux_val (mux_ctl_t'(regs.direct[3:0])),   // azmux field of direct
    .az_azmux   (az_azmux),
    .az_pc_sw   (az_pc_sw),
    .az_led     (az_led),
    .az_monitor (az_monitor)
  );

  cond_mode_mux i_cond_mode_mux (
    .clk        (clk),
    .rst_n      (rst_n),
    .regs       (regs),
    .az_azmux   (az_azmux),
    .az_pc_sw   (az_pc_sw),
    .az_led     (az_led),
    .az_monitor (az_monitor),
    .cond_out   (cond_out)
  );

endmodule

`default_nettype wire

// File: afe_ctl_assert.sv
////////////////////
// afe control checker
// reset state and auto-zero pre-charge checks bound into the top level
////////////////////

`default_nettype none

module afe_ctl_assert
  import afe_ctl_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input reg_file_t  regs,
  input cond_word_t cond_out,
  input logic       spi_miso
);

  logic az_now;

  assign az_now = (regs.mode[2:0] == MODE_AZ);   // modulator running

  // outputs leave reset cleared
  a_reset_clear: assert property (@(posedge clk)
    !rst_n |=> (cond_out == '0 && !spi_miso))
    else $error("cond_out or spi_miso not zero after reset");

  // pre-charge closed exactly while azmux sits on the signal select
  a_az_precharge: assert property (@(posedge clk) disable iff (!rst_n)
    (az_now && $past(az_now)) |->
      (cond_out.sig_pc_sw == (cond_out.azmux == mux_ctl_t'(regs.direct[3:0]))))
    else $error("auto-zero pre-charge switch disagrees with azmux");

endmodule

bind afe_ctl_top afe_ctl_assert i_afe_ctl_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .regs     (regs),
  .cond_out (cond_out),
  .spi_miso (spi_miso)
);

`default_nettype wire

// File: tb_afe_ctl.sv
////////////////////
// afe control testbench
// spi register access followed by static, count, alternation and auto-zero modes
////////////////////

`default_nettype none

`include "afe_ctl_settings.svh"

module tb_afe_ctl
  import afe_ctl_pkg::*;
();

  localparam int SPI_HALF        = 4;      // clk cycles per spi half-period
  localparam int SPI_GAP         = 8;      // idle after cs rises to cover the register update
  localparam int SETTLE          = 10;
  localparam int WATCHDOG_CYCLES = 20000;

  // what the compare process checks each cycle
  localparam int CHK_OFF    = 0;
  localparam int CHK_STATIC = 1;
  localparam int CHK_COUNT  = 2;
  localparam int CHK_ALT    = 3;
  localparam int CHK_AZ     = 4;

  localparam logic [2:0] STATIC_MODES [4] = '{3'd0, 3'd1, 3'd3, 3'd7};
  localparam logic [6:0] ADDR_UNMAPPED    = 7'h55;

  logic       clk;
  logic       rst_n;
  logic       spi_clk;
  logic       spi_cs;
  logic       spi_mosi;
  logic       spi_miso;
  cond_word_t cond_out;

  logic [31:0]              sh_led;       // shadow copies of the written registers
  logic [31:0]              sh_mode;
  logic [31:0]              sh_direct;
  logic [31:0]              sh_direct2;
  int                       chk_kind;
  int                       errors;
  int                       checks;
  int                       err_mark;     // error count at start of the current test
  int                       tests;
  logic [`AFE_NUM_BITS-1:0] prev_w;
  logic                     prev_ok;

  afe_ctl_top i_afe_ctl_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .spi_clk  (spi_clk),
    .spi_cs   (spi_cs),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .cond_out (cond_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // reference model

  // static modes where 6 and 7 give zero
  function automatic cond_word_t expected_static(input logic [2:0] mode,
                                                 input logic [31:0] direct);
    case (mode)
      3'd1:    return '1;
      3'd3:    return cond_word_t'(direct[`AFE_NUM_BITS-1:0]);
      default: return '0;
    endcase
  endfunction

  // auto-zero word for one phase
  function automatic cond_word_t expected_az(input logic [31:0] direct, input logic zero_phase,
                                             input logic led);
    cond_word_t w;
    w = cond_word_t'(direct[`AFE_NUM_BITS-1:0]);   // pass-through fields
    if (zero_phase)
      w.azmux = '{en: 1'b1, addr: 3'(`AFE_AZ_LO_CODE)};
    w.sig_pc_sw = ~zero_phase;
    w.led0      = led;
    w.monitor   = {6'b0, led, zero_phase};
    return w;
  endfunction

  ////////////////////
  // reporting helpers

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %-10s done, %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  ////////////////////
  // spi master

  // one 40 bit mode 0 frame sent msb first that returns the 32 data bits seen on miso
  task automatic spi_frame(input logic wr, input logic [6:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {wr, addr, wdata};
    rdata = '0;
    @(negedge clk);
    spi_cs = 1'b0;
    for (int k = 39; k >= 0; k--)
    begin
      spi_mosi = frame[k];                 // set up while sclk low
      wait_cycles(SPI_HALF);
      if (k < 32)
        rdata[k] = spi_miso;               // miso settled in the data phase
      spi_clk = 1'b1;
      wait_cycles(SPI_HALF);
      spi_clk = 1'b0;
    end
    wait_cycles(SPI_HALF);
    spi_cs   = 1'b1;                       // write lands here
    spi_mosi = 1'b0;
    wait_cycles(SPI_GAP);
  endtask

  task automatic reg_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    spi_frame(1'b1, addr, data, ignored);
    case (addr)
      `AFE_ADDR_LED:     sh_led     = data;
      `AFE_ADDR_MODE:    sh_mode    = data;
      `AFE_ADDR_DIRECT:  sh_direct  = data;
      `AFE_ADDR_DIRECT2: sh_direct2 = data;
      default:           ;                 // nothing stored for unmapped
    endcase
  endtask

  task automatic check_reg(input string name, input logic [6:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    spi_frame(1'b0, addr, 32'h0, got);
    checks++;
    assert (got == exp)
    else value_error(name, got, exp);
  endtask

  ////////////////////
  // compare process sampling cond_out at the falling edge where it is stable
  always @(negedge clk)
  begin : compare
    cond_word_t               exp_w;
    logic [`AFE_NUM_BITS-1:0] got_w;
    logic [`AFE_NUM_BITS-1:0] nxt_w;
    logic                     zero_ph;

    got_w = cond_out;
    case (chk_kind)
      CHK_STATIC:
      begin
        exp_w = expected_static(sh_mode[2:0], sh_direct);
        checks++;
        assert (cond_out == exp_w)
        else value_error("cond_out", {3'b0, got_w}, {3'b0, exp_w});
      end
      CHK_COUNT:
      begin
        nxt_w = prev_w + 1'b1;             // wraps at 2^29
        if (prev_ok)
        begin
          checks++;
          assert (got_w == nxt_w)
          else value_error("cond_out", {3'b0, got_w}, {3'b0, nxt_w});
        end
        prev_w  = got_w;
        prev_ok = 1'b1;
      end
      CHK_ALT:
      begin
        checks++;
        assert (got_w == sh_direct[28:0] || got_w == sh_direct2[28:0])
        else note_failure($sformatf("** Error: cond_out = 0x%08h, expected 0x%08h or 0x%08h",
                                    {3'b0, got_w}, {3'b0, sh_direct[28:0]},
                                    {3'b0, sh_direct2[28:0]}));
      end
      CHK_AZ:
      begin
        zero_ph = (cond_out.azmux != mux_ctl_t'(sh_direct[3:0]));   // off the signal select
        exp_w   = expected_az(sh_direct, zero_ph, cond_out.led0);
        checks++;
        assert (cond_out == exp_w)
        else value_error("cond_out", {3'b0, got_w}, {3'b0, exp_w});
      end
      default:
        prev_ok = 1'b0;
    endcase
  end

  ////////////////////
  // stimulus
  initial
  begin : stimulus
    logic [31:0]              d;
    logic [31:0]              d2;
    logic [`AFE_NUM_BITS-1:0] cur;
    logic [`AFE_NUM_BITS-1:0] prev;
    int                       run_len;
    int                       swaps;
    bit                       seen_a;
    bit                       seen_b;
    int                       cyc;

    rst_n      = 1'b0;
    spi_clk    = 1'b0;
    spi_cs     = 1'b1;
    spi_mosi   = 1'b0;
    chk_kind   = CHK_OFF;
    prev_ok    = 1'b0;
    prev_w     = '0;
    sh_led     = '0;
    sh_mode    = '0;
    sh_direct  = '0;
    sh_direct2 = '0;
    void'($urandom(32'h62b4d572));
    repeat (16) @(posedge clk);            // reset held over 16 rising edges
    @(negedge clk);
    rst_n = 1'b1;

    // reset state and register readback
    @(negedge clk);
    checks += 2;
    assert (cond_out == '0)
    else value_error("cond_out", {3'b0, cond_out}, 32'h0);
    assert (spi_miso == 1'b0)
    else value_error("spi_miso", {31'b0, spi_miso}, 32'h0);
    reg_write(`AFE_ADDR_LED, $urandom());
    reg_write(`AFE_ADDR_MODE, $urandom() & 32'hffff_fff8);   // keep mode at zero
    reg_write(`AFE_ADDR_DIRECT, $urandom());
    reg_write(`AFE_ADDR_DIRECT2, $urandom());
    reg_write(ADDR_UNMAPPED, $urandom());                    // dropped
    check_reg("led", `AFE_ADDR_LED, sh_led);
    check_reg("mode", `AFE_ADDR_MODE, sh_mode);
    check_reg("direct", `AFE_ADDR_DIRECT, sh_direct);
    check_reg("direct2", `AFE_ADDR_DIRECT2, sh_direct2);
    check_reg("unmapped", ADDR_UNMAPPED, 32'h0);
    check_reg("addr 0", 7'h00, 32'h0);
    finish_test("readback");

    // zero, ones, direct and code 7
    reg_write(`AFE_ADDR_DIRECT, $urandom());
    for (int s = 0; s < 4; s++)
    begin
      reg_write(`AFE_ADDR_MODE, {29'b0, STATIC_MODES[s]});
      wait_cycles(SETTLE);
      chk_kind <= CHK_STATIC;
      wait_cycles(20);
      chk_kind <= CHK_OFF;
    end
    finish_test("static");

    // free-running count
    reg_write(`AFE_ADDR_MODE, 32'(MODE_COUNT));
    wait_cycles(SETTLE);
    chk_kind <= CHK_COUNT;
    wait_cycles(50);
    chk_kind <= CHK_OFF;
    finish_test("count");

    // direct / direct2 alternation
    d  = $urandom();
    d2 = $urandom();
    if (d2[28:0] == d[28:0])
      d2 = ~d;                             // both values must be told apart
    reg_write(`AFE_ADDR_DIRECT, d);
    reg_write(`AFE_ADDR_DIRECT2, d2);
    reg_write(`AFE_ADDR_MODE, 32'(MODE_ALT));
    wait_cycles(SETTLE);
    chk_kind <= CHK_ALT;
    prev    = cond_out;
    run_len = 1;
    swaps   = 0;
    seen_a  = (prev == d[28:0]);
    seen_b  = (prev == d2[28:0]);
    for (cyc = 1; cyc < 100; cyc++)
    begin
      @(negedge clk);
      cur = cond_out;
      if (cur != prev)
      begin
        if (swaps > 0)                     // first run is partial
        begin
          checks++;
          assert (run_len == `AFE_ALT_PERIOD)
          else value_error("alt run length", run_len, `AFE_ALT_PERIOD);
        end
        swaps++;
        run_len = 1;
      end
      else
        run_len++;
      seen_a |= (cur == d[28:0]);
      seen_b |= (cur == d2[28:0]);
      prev = cur;
    end
    chk_kind <= CHK_OFF;
    checks += 2;
    assert (seen_a && seen_b)
    else note_failure("alternation did not show both direct and direct2");
    assert (swaps >= 2)
    else note_failure("alternation swapped fewer than two times in 100 cycles");
    finish_test("alternate");

    // auto-zero with the signal select kept apart from the zero reference
    d = $urandom();
    if (d[3:0] == {1'b1, 3'(`AFE_AZ_LO_CODE)})
      d[3] = 1'b0;
    reg_write(`AFE_ADDR_DIRECT, d);
    reg_write(`AFE_ADDR_MODE, 32'(MODE_AZ));
    chk_kind <= CHK_AZ;
    seen_a = 1'b0;
    seen_b = 1'b0;
    for (cyc = 0; cyc < 40 && !(seen_a && seen_b); cyc++)
    begin
      @(negedge clk);
      if (cond_out.sig_pc_sw)
        seen_a = 1'b1;                     // signal phase
      else
        seen_b = 1'b1;                     // zero phase
    end
    checks++;
    assert (seen_a && seen_b)
    else note_failure("auto-zero did not show both phases within 40 cycles");
    wait_cycles(4 * `AFE_AZ_PERIOD);       // a couple of led toggles
    chk_kind <= CHK_OFF;
    finish_test("auto-zero");

    $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // overall limit on run time
  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout, run exceeded %0d clock cycles", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: afe_ctl_top.f
+incdir+.
afe_ctl_pkg.sv
spi_reg_bank.sv
az_modulator.sv
cond_mode_mux.sv
afe_ctl_top.sv
afe_ctl_assert.sv
tb_afe_ctl.sv

// File: Bender.yml
package:
  name: afe_ctl

sources:
  - include_dirs:
      - .
    files:
      - afe_ctl_pkg.sv
      - spi_reg_bank.sv
      - az_modulator.sv
      - cond_mode_mux.sv
      - afe_ctl_top.sv
      - target: test
        files:
          - afe_ctl_assert.sv
          - tb_afe_ctl.sv
